//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP = tb_idct
FILELIST = tb.f
OBJDIR = obj_dir

SRCS := $(shell cat $(FILELIST))
BIN = $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(OBJDIR)/V%: $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) -Mdir $(OBJDIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJDIR)

//--- block_buffer.sv
module block_buffer (
	input logic Clock,
	input logic Resetn,
	input idct_pkg::coeff_t coeff_in,
	input logic coeff_valid,
	output logic coeff_ready,
	output idct_pkg::pixel_beat_t pix_out,
	output logic pix_valid,
	input logic pix_ready,
	input idct_pkg::pair_addr_t rd_addr,
	output idct_pkg::block_word_t rd_data,
	input idct_pkg::buf_write_t wr,
	output logic block_loaded,
	input logic block_done
);
	import idct_pkg::*;

	typedef enum logic [1:0] {PH_LOAD, PH_BUSY, PH_UNLOAD} phase_t;

	phase_t phase;
	block_word_t mem [PAIR_WORDS];
	block_word_t pair_word;
	block_word_t rd_word;
	block_word_t skid [2];
	coeff_t first_coeff;
	pair_addr_t raddr;
	logic [5:0] in_cnt;
	logic [5:0] out_cnt;
	logic [5:0] rd_cnt;
	logic [1:0] count;
	logic wsel;
	logic rsel;
	logic inflight;
	logic unloading;
	logic in_xfer;
	logic out_xfer;
	logic issue;
	logic pop_word;

	assign unloading = (phase == PH_UNLOAD);
	assign coeff_ready = (phase == PH_LOAD);
	assign in_xfer = coeff_valid & coeff_ready;
	assign pix_valid = unloading && (count != 2'd0);
	assign out_xfer = pix_valid & pix_ready;
	assign pop_word = out_xfer & out_cnt[0];

	// prefetch while the skid plus the read in flight hold fewer than two words
	assign issue = unloading && !rd_cnt[5] && (count + 2'(inflight) < 2'd2);
	assign raddr = unloading ? rd_cnt[4:0] : rd_addr;
	assign rd_data = rd_word;

	always_comb begin
		pair_word.coeffs.hi = first_coeff;
		pair_word.coeffs.lo = coeff_in;
		pix_out.data = out_cnt[0] ? skid[rsel].pixels.lo : skid[rsel].pixels.hi;
		pix_out.last = (out_cnt == 6'(BLOCK_SIZE - 1));
	end

	always_ff @(posedge Clock) begin
		if (in_xfer && in_cnt[0]) begin
			mem[in_cnt[5:1]] <= pair_word;
		end else if (wr.en) begin
			mem[wr.addr] <= wr.word;
		end
		rd_word <= mem[raddr];
		if (in_xfer && !in_cnt[0]) begin
			first_coeff <= coeff_in;
		end
		if (inflight) begin
			skid[wsel] <= rd_word;
		end
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			phase <= PH_LOAD;
			in_cnt <= '0;
			out_cnt <= '0;
			rd_cnt <= '0;
			count <= '0;
			wsel <= 1'b0;
			rsel <= 1'b0;
			inflight <= 1'b0;
			block_loaded <= 1'b0;
		end else begin
			block_loaded <= in_xfer && (in_cnt == 6'(BLOCK_SIZE - 1));
			inflight <= issue;
			count <= count + 2'(inflight) - 2'(pop_word);
			if (in_xfer) begin
				in_cnt <= in_cnt + 6'd1;
			end
			if (issue) begin
				rd_cnt <= rd_cnt + 6'd1;
			end
			if (inflight) begin
				wsel <= ~wsel;
			end
			if (pop_word) begin
				rsel <= ~rsel;
			end
			if (out_xfer) begin
				out_cnt <= out_cnt + 6'd1;
			end
			case (phase)
				PH_LOAD: begin
					if (in_xfer && in_cnt == 6'(BLOCK_SIZE - 1)) begin
						phase <= PH_BUSY;
					end
				end
				PH_BUSY: begin
					if (block_done) begin
						rd_cnt <= '0;
						phase <= PH_UNLOAD;
					end
				end
				PH_UNLOAD: begin
					// input reopens on the final pixel beat
					if (out_xfer && pix_out.last) begin
						phase <= PH_LOAD;
					end
				end
				default: phase <= PH_LOAD;
			endcase
		end
	end

endmodule

//--- idct_assertions.sv
module idct_assertions (
	input logic Clock,
	input logic Resetn,
	input logic coeff_ready,
	input idct_pkg::pixel_beat_t pix_out,
	input logic pix_valid,
	input logic pix_ready
);

	// stalled beat holds
	hold_beat: assert property (@(posedge Clock) disable iff (!Resetn)
		pix_valid && !pix_ready |=> pix_valid && $stable(pix_out))
		else $error("pix_out changed while the sink stalled");

	// once closed, input stays closed through busy and unload until the last beat
	input_closed: assert property (@(posedge Clock) disable iff (!Resetn)
		!coeff_ready && !(pix_valid && pix_ready && pix_out.last) |=> !coeff_ready)
		else $error("coeff_ready rose before the final pixel beat");

	valid_known: assert property (@(posedge Clock) disable iff (!Resetn)
		!$isunknown(pix_valid))
		else $error("pix_valid unknown after reset");

endmodule

bind idct_top idct_assertions u_assertions (
	.Clock (Clock),
	.Resetn (Resetn),
	.coeff_ready (coeff_ready),
	.pix_out (pix_out),
	.pix_valid (pix_valid),
	.pix_ready (pix_ready)
);

//--- idct_pkg.sv
package idct_pkg;

	localparam int N = 8;
	localparam int BLOCK_SIZE = N * N;
	localparam int PAIR_WORDS = BLOCK_SIZE / 2;

	// scaling after each matrix pass
	localparam int PASS1_SHIFT = 8;
	localparam int PASS2_SHIFT = 16;

	typedef logic signed [15:0] coeff_t;
	typedef logic [7:0] pixel_t;
	typedef logic signed [31:0] acc_t;
	typedef logic [4:0] pair_addr_t;
	typedef logic [5:0] elem_addr_t;

	// round(4096 * a(k) * cos((2n+1)k pi/16)), one row per k
	localparam coeff_t COS_TABLE [BLOCK_SIZE] = '{
		1448, 1448, 1448, 1448, 1448, 1448, 1448, 1448,
		2009, 1703, 1138, 400, -400, -1138, -1703, -2009,
		1892, 784, -784, -1892, -1892, -784, 784, 1892,
		1703, -400, -2009, -1138, 1138, 2009, 400, -1703,
		1448, -1448, -1448, 1448, 1448, -1448, -1448, 1448,
		1138, -2009, 400, 1703, -1703, -400, 2009, -1138,
		784, -1892, 1892, -784, -784, 1892, -1892, 784,
		400, -1138, 1703, -2009, 2009, -1703, 1138, -400
	};

	typedef struct packed {
		coeff_t hi;
		coeff_t lo;
	} coeff_pair_t;

	typedef struct packed {
		logic [15:0] unused;
		pixel_t hi;
		pixel_t lo;
	} pixel_pair_t;

	// buffer word, coefficients on the way in and pixels on the way out
	typedef union packed {
		coeff_pair_t coeffs;
		pixel_pair_t pixels;
	} block_word_t;

	typedef struct packed {
		pixel_t data;
		logic last;
	} pixel_beat_t;

	typedef struct packed {
		logic en;
		pair_addr_t addr;
		block_word_t word;
	} buf_write_t;

	typedef struct packed {
		logic pass;
		logic half;
		logic load;
		logic add;
	} mac_ctrl_t;

endpackage

//--- idct_sequencer.sv
module idct_sequencer (
	input logic Clock,
	input logic Resetn,
	input logic block_loaded,
	output logic block_done,
	output idct_pkg::pair_addr_t rd_addr,
	input idct_pkg::block_word_t rd_data,
	output idct_pkg::buf_write_t wr,
	output logic t_wr_en,
	output idct_pkg::elem_addr_t t_wr_addr,
	output idct_pkg::acc_t t_wr_data,
	output idct_pkg::elem_addr_t t_rd_addr_a,
	output idct_pkg::elem_addr_t t_rd_addr_b,
	input idct_pkg::acc_t t_rd_data_a,
	input idct_pkg::acc_t t_rd_data_b,
	output idct_pkg::mac_ctrl_t ctrl,
	output idct_pkg::elem_addr_t cos_index,
	output idct_pkg::acc_t operands [4],
	input idct_pkg::acc_t t_value,
	input idct_pkg::pixel_t pixel
);
	import idct_pkg::*;

	typedef enum logic [2:0] {S_IDLE, S_LEAD_IN, S_ROW, S_COLUMN, S_LEAD_OUT} seq_state_t;

	seq_state_t state;
	logic pass;
	logic running;
	logic [2:0] outer;
	logic [2:0] ld_cnt;
	logic [3:0] cnt;
	logic [1:0] cap_idx;
	logic [1:0] fin_q;
	logic [1:0] pass_q;
	elem_addr_t elem_q [2];
	acc_t opnd [8];
	pixel_t pix_hold [N];

	assign running = (state == S_ROW) || (state == S_COLUMN);
	assign cap_idx = ld_cnt[1:0] - 2'd1;

	// lead-in fetch: S' pairs of row outer, or column outer of T two rows at a time
	assign rd_addr = {outer, ld_cnt[1:0]};
	assign t_rd_addr_a = {ld_cnt[1:0], 1'b0, outer};
	assign t_rd_addr_b = {ld_cnt[1:0], 1'b1, outer};

	// cnt[3:1] is the output element, cnt[0] the half of k
	assign cos_index = pass ? {cnt[3:1], outer} : {outer, cnt[3:1]};

	always_comb begin
		ctrl.pass = pass;
		ctrl.half = cnt[0];
		ctrl.load = running & ~cnt[0];
		ctrl.add = running & cnt[0];
		for (int j = 0; j < 4; j++) begin
			operands[j] = opnd[{cnt[0], 2'(j)}];
		end
	end

	// accumulator is final two cycles after the second half
	assign t_wr_en = fin_q[1] & ~pass_q[1];
	assign t_wr_addr = elem_q[1];
	assign t_wr_data = t_value;

	// odd column completes the pixel pair
	always_comb begin
		wr.en = fin_q[1] & pass_q[1] & elem_q[1][0];
		wr.addr = elem_q[1][5:1];
		wr.word.pixels.unused = '0;
		wr.word.pixels.hi = pix_hold[elem_q[1][5:3]];
		wr.word.pixels.lo = pixel;
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= S_IDLE;
			pass <= 1'b0;
			outer <= '0;
			ld_cnt <= '0;
			cnt <= '0;
			fin_q <= '0;
			block_done <= 1'b0;
		end else begin
			block_done <= 1'b0;
			fin_q <= {fin_q[0], running & cnt[0]};
			case (state)
				S_IDLE: begin
					if (block_loaded) begin
						pass <= 1'b0;
						outer <= '0;
						state <= S_LEAD_IN;
					end
				end
				S_LEAD_IN: begin
					ld_cnt <= ld_cnt + 3'd1;
					if (ld_cnt == 3'd4) begin
						ld_cnt <= '0;
						state <= pass ? S_COLUMN : S_ROW;
					end
				end
				S_ROW, S_COLUMN: begin
					cnt <= cnt + 4'd1;
					if (cnt == 4'd15) begin
						outer <= outer + 3'd1;
						state <= S_LEAD_IN;
						if (outer == 3'(N - 1)) begin
							pass <= 1'b1;
							if (state == S_COLUMN) begin
								state <= S_LEAD_OUT;
							end
						end
					end
				end
				S_LEAD_OUT: begin
					if (wr.en && wr.addr == 5'(PAIR_WORDS - 1)) begin
						block_done <= 1'b1;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		pass_q <= {pass_q[0], pass};
		elem_q[0] <= cos_index;
		elem_q[1] <= elem_q[0];
		if (state == S_LEAD_IN && ld_cnt != 3'd0) begin
			if (pass) begin
				opnd[{cap_idx, 1'b0}] <= t_rd_data_a;
				opnd[{cap_idx, 1'b1}] <= t_rd_data_b;
			end else begin
				opnd[{cap_idx, 1'b0}] <= acc_t'(rd_data.coeffs.hi);
				opnd[{cap_idx, 1'b1}] <= acc_t'(rd_data.coeffs.lo);
			end
		end
		if (fin_q[1] && pass_q[1] && !elem_q[1][0]) begin
			pix_hold[elem_q[1][5:3]] <= pixel;
		end
	end

endmodule

//--- idct_top.sv
module idct_top (
	input logic Clock,
	input logic Resetn,
	input idct_pkg::coeff_t coeff_in,
	input logic coeff_valid,
	output logic coeff_ready,
	output idct_pkg::pixel_beat_t pix_out,
	output logic pix_valid,
	input logic pix_ready
);
	import idct_pkg::*;

	pair_addr_t rd_addr;
	block_word_t rd_data;
	buf_write_t wr;
	logic block_loaded;
	logic block_done;
	logic t_wr_en;
	elem_addr_t t_wr_addr;
	elem_addr_t t_rd_addr_a;
	elem_addr_t t_rd_addr_b;
	elem_addr_t cos_index;
	acc_t t_wr_data;
	acc_t t_rd_data_a;
	acc_t t_rd_data_b;
	acc_t t_value;
	acc_t operands [4];
	mac_ctrl_t ctrl;
	pixel_t pixel;

	block_buffer u_buffer (.*);

	idct_sequencer u_sequencer (.*);

	mac_datapath u_datapath (.*);

	transpose_ram u_tram (
		.Clock (Clock),
		.wr_en (t_wr_en),
		.wr_addr (t_wr_addr),
		.wr_data (t_wr_data),
		.rd_addr_a (t_rd_addr_a),
		.rd_addr_b (t_rd_addr_b),
		.rd_data_a (t_rd_data_a),
		.rd_data_b (t_rd_data_b)
	);

endmodule

//--- mac_datapath.sv
module mac_datapath (
	input logic Clock,
	input logic Resetn,
	input idct_pkg::mac_ctrl_t ctrl,
	input idct_pkg::elem_addr_t cos_index,
	input idct_pkg::acc_t operands [4],
	output idct_pkg::acc_t t_value,
	output idct_pkg::pixel_t pixel
);
	import idct_pkg::*;

	coeff_t cos_q [4];
	acc_t op_q [4];
	acc_t prod [4];
	acc_t sum;
	acc_t acc;
	acc_t scaled;
	logic [2:0] col;
	logic load_q;
	logic add_q;

	// pass one walks C by output column n, pass two by output row m
	assign col = ctrl.pass ? cos_index[5:3] : cos_index[2:0];

	// rom read and operand capture share one register stage
	always_ff @(posedge Clock) begin
		for (int j = 0; j < 4; j++) begin
			cos_q[j] <= COS_TABLE[{ctrl.half, 2'(j), col}];
			op_q[j] <= operands[j];
		end
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			load_q <= 1'b0;
			add_q <= 1'b0;
		end else begin
			load_q <= ctrl.load;
			add_q <= ctrl.add;
		end
	end

	always_comb begin
		sum = '0;
		for (int j = 0; j < 4; j++) begin
			prod[j] = op_q[j] * acc_t'(cos_q[j]);
			sum = sum + prod[j];
		end
	end

	always_ff @(posedge Clock) begin
		if (load_q) begin
			acc <= sum;
		end else if (add_q) begin
			acc <= acc + sum;
		end
	end

	assign t_value = acc >>> PASS1_SHIFT;
	assign scaled = acc >>> PASS2_SHIFT;

	// clip to 0..255
	always_comb begin
		if (acc < 0) begin
			pixel = '0;
		end else if (scaled > 255) begin
			pixel = '1;
		end else begin
			pixel = scaled[7:0];
		end
	end

endmodule

//--- tb.f
idct_pkg.sv
block_buffer.sv
transpose_ram.sv
mac_datapath.sv
idct_sequencer.sv
idct_top.sv
idct_assertions.sv
tb_idct.sv

//--- tb_idct.sv
module tb_idct;
	import idct_pkg::*;

	localparam logic [15:0] LFSR_POLY = 16'hB400;
	localparam int TIMEOUT = 2000;

	logic Clock = 1'b0;
	logic Resetn;
	coeff_t coeff_in;
	logic coeff_valid;
	logic coeff_ready;
	pixel_beat_t pix_out;
	logic pix_valid;
	logic pix_ready;

	coeff_t blk [BLOCK_SIZE];
	pixel_t expected [BLOCK_SIZE];
	logic [15:0] lfsr;
	int beats = 0;
	int idx;
	int beat_errors = 0;
	int check_errors = 0;
	int timeouts = 0;

	idct_top uut (.*);

	always #2 Clock = ~Clock;

	// Galois form, shifts right
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ LFSR_POLY;
		end
		return s >> 1;
	endfunction

	function automatic int rand_bits(input int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			r = (r << 1) | int'(lfsr[0]);
			lfsr = lfsr_step(lfsr);
		end
		return r;
	endfunction

	// both matrix passes with 32-bit wrapping sums, then clip
	function automatic void compute_reference();
		acc_t t_mat [BLOCK_SIZE];
		acc_t sum;
		for (int r = 0; r < N; r++) begin
			for (int n = 0; n < N; n++) begin
				sum = 0;
				for (int k = 0; k < N; k++) begin
					sum = sum + acc_t'(blk[r * N + k]) * acc_t'(COS_TABLE[k * N + n]);
				end
				t_mat[r * N + n] = sum >>> PASS1_SHIFT;
			end
		end
		for (int m = 0; m < N; m++) begin
			for (int n = 0; n < N; n++) begin
				sum = 0;
				for (int k = 0; k < N; k++) begin
					sum = sum + acc_t'(COS_TABLE[k * N + m]) * t_mat[k * N + n];
				end
				if (sum < 0) begin
					expected[m * N + n] = 8'd0;
				end else if ((sum >>> PASS2_SHIFT) > 255) begin
					expected[m * N + n] = 8'd255;
				end else begin
					expected[m * N + n] = pixel_t'(sum >>> PASS2_SHIFT);
				end
			end
		end
	endfunction

	task automatic fill_dc(input coeff_t dc);
		for (int i = 0; i < BLOCK_SIZE; i++) begin
			blk[i] = '0;
		end
		blk[0] = dc;
	endtask

	task automatic fill_random();
		for (int i = 0; i < BLOCK_SIZE; i++) begin
			blk[i] = coeff_t'(rand_bits(10) - 512);
		end
	endtask

	task automatic send_block();
		int t;
		for (int i = 0; i < BLOCK_SIZE; i++) begin
			coeff_in <= blk[i];
			coeff_valid <= 1'b1;
			t = 0;
			do begin
				@(posedge Clock);
				t++;
			end while (!coeff_ready && t < TIMEOUT);
			if (!coeff_ready) begin
				timeouts++;
				$display("Timeout: input stream did not take coefficient %0d", i);
				coeff_valid <= 1'b0;
				return;
			end
		end
		coeff_valid <= 1'b0;
	endtask

	task automatic run_block(input logic stalls);
		int target;
		int t;
		if (timeouts != 0) begin
			return;
		end
		compute_reference();
		target = beats + BLOCK_SIZE;
		send_block();
		if (timeouts != 0) begin
			return;
		end
		t = 0;
		do begin
			pix_ready <= stalls ? 1'(rand_bits(1)) : 1'b1;
			@(posedge Clock);
			t++;
			if (beats != target && coeff_ready) begin
				check_errors++;
				$display("Input stream reopened before the final pixel beat");
			end
		end while (beats != target && t < TIMEOUT);
		pix_ready <= 1'b1;
		if (beats != target) begin
			timeouts++;
			$display("Timeout: only %0d of 64 pixels arrived", beats + BLOCK_SIZE - target);
		end else if (!coeff_ready) begin
			check_errors++;
			$display("Input stream stayed closed after the final pixel beat");
		end
	endtask

	// compare every transferred pixel against the reference
	always @(posedge Clock) begin
		if (pix_valid && pix_ready) begin
			idx = beats % BLOCK_SIZE;
			if (pix_out.data !== expected[idx]) begin
				beat_errors++;
				$display("Error pix_out.data exp=%h got=%h beat %0d",
					expected[idx], pix_out.data, idx);
			end
			if (pix_out.last !== (idx == BLOCK_SIZE - 1)) begin
				beat_errors++;
				$display("Error pix_out.last exp=%h got=%h beat %0d",
					idx == BLOCK_SIZE - 1, pix_out.last, idx);
			end
			if (coeff_ready !== 1'b0) begin
				beat_errors++;
				$display("Error coeff_ready exp=%h got=%h beat %0d", 1'b0, coeff_ready, idx);
			end
			beats <= beats + 1;
		end
	end

	initial begin
		Resetn = 1'b0;
		coeff_in = '0;
		coeff_valid = 1'b0;
		pix_ready = 1'b0;
		lfsr = 16'd2;
		repeat (2) @(posedge Clock);
		Resetn <= 1'b1;
		pix_ready <= 1'b1;
		@(posedge Clock);
		if (pix_valid !== 1'b0) begin
			check_errors++;
			$display("Error pix_valid exp=%h got=%h", 1'b0, pix_valid);
		end
		if (coeff_ready !== 1'b1) begin
			check_errors++;
			$display("Error coeff_ready exp=%h got=%h", 1'b1, coeff_ready);
		end
		fill_dc(16'sd800);
		run_block(1'b0);
		fill_random();
		run_block(1'b0);
		// clipping at both ends
		fill_dc(16'sd20000);
		run_block(1'b0);
		fill_dc(-16'sd20000);
		run_block(1'b0);
		fill_random();
		run_block(1'b1);
		fill_random();
		run_block(1'b0);
		$display("Errors: beat %0d, check %0d, timeout %0d", beat_errors, check_errors, timeouts);
		if (beat_errors == 0 && check_errors == 0 && timeouts == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- transpose_ram.sv
module transpose_ram (
	input logic Clock,
	input logic wr_en,
	input idct_pkg::elem_addr_t wr_addr,
	input idct_pkg::acc_t wr_data,
	input idct_pkg::elem_addr_t rd_addr_a,
	input idct_pkg::elem_addr_t rd_addr_b,
	output idct_pkg::acc_t rd_data_a,
	output idct_pkg::acc_t rd_data_b
);
	import idct_pkg::*;

	// T values, addressed {row, column}
	acc_t mem [BLOCK_SIZE];

	always_ff @(posedge Clock) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data_a <= mem[rd_addr_a];
		rd_data_b <= mem[rd_addr_b];
	end

endmodule
